//--- dv/fu_cluster_model.svh
`ifndef FU_CLUSTER_MODEL_SVH
`define FU_CLUSTER_MODEL_SVH

////////////////////////////////////////////////////////////
// Model state
////////////////////////////////////////////////////////////

// What the outputs must show two cycles after an issue cycle
typedef struct packed {
  logic [fu_pkg::LANE_COUNT-1:0] valid;
  logic [fu_pkg::LANE_COUNT-1:0][fu_pkg::DATA_WIDTH-1:0] data;
} expect_t;

localparam logic [31:0] LFSR_SEED = 32'hfec4_ced7;
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

localparam int MODE_ALU = 0;
localparam int MODE_SHIFT = 1;
localparam int MODE_ANY = 2;
localparam int MODE_IDLE = 3;

logic [31:0] lfsr_state;
expect_t exp_q [$];
logic [fu_pkg::LANE_COUNT-1:0][fu_pkg::DATA_WIDTH-1:0] hist_now; // Issued one cycle back
logic [fu_pkg::LANE_COUNT-1:0][fu_pkg::DATA_WIDTH-1:0] hist_prev; // Issued two cycles back
logic [fu_pkg::LANE_COUNT-1:0] now_ok;
logic [fu_pkg::LANE_COUNT-1:0] prev_ok;
fu_pkg::issue_t next_ops [fu_pkg::LANE_COUNT];

// One LFSR step per bit, the bit shifted out is the bit taken
function automatic logic [63:0] rand_bits(input int n);
  logic [63:0] r;
  logic out_bit;
  r = '0;
  for (int i = 0; i < n; i++) begin
    out_bit = lfsr_state[0];
    lfsr_state = (lfsr_state >> 1) ^ (out_bit ? LFSR_TAPS : 32'h0);
    r = {r[62:0], out_bit};
  end
  return r;
endfunction

function automatic fu_pkg::data_t alu_model(input fu_pkg::alu_op_e op,
                                            input fu_pkg::data_t a, input fu_pkg::data_t b);
  logic [5:0] amt;
  amt = b[5:0];
  case (op)
    fu_pkg::op_sub: return a - b;
    fu_pkg::op_and: return a & b;
    fu_pkg::op_or: return a | b;
    fu_pkg::op_xor: return a ^ b;
    fu_pkg::op_shl: return a << amt;
    fu_pkg::op_shr: return a >> amt;
    fu_pkg::op_sar: return fu_pkg::data_t'($signed(a) >>> amt);
    default: return a + b;
  endcase
endfunction

function automatic fu_pkg::data_t resolve(input fu_pkg::fwd_sel_t sel,
                                          input fu_pkg::data_t issued);
  case (sel.src)
    fu_pkg::src_now: return hist_now[sel.lane];
    fu_pkg::src_prev: return hist_prev[sel.lane];
    default: return issued;
  endcase
endfunction

// Only slots known to hold a valid, unflushed result are ever chosen
function automatic fu_pkg::fwd_sel_t pick_sel();
  fu_pkg::fwd_sel_t sel;
  logic [63:0] kind;
  logic [63:0] lane;
  kind = rand_bits(2);
  lane = rand_bits(fu_pkg::LANE_IDX_WIDTH);
  sel.lane = lane[fu_pkg::LANE_IDX_WIDTH-1:0];
  sel.src = fu_pkg::src_issue;
  if (kind[0] && now_ok[sel.lane]) begin
    sel.src = fu_pkg::src_now;
  end else if (kind[1] && prev_ok[sel.lane]) begin
    sel.src = fu_pkg::src_prev;
  end
  return sel;
endfunction

function automatic fu_pkg::issue_t make_op(input int mode, input bit fwd_on, input bit may_idle);
  fu_pkg::issue_t iss;
  logic [63:0] r;
  iss = '0;
  if (mode == MODE_IDLE) begin
    return iss;
  end
  r = rand_bits(1);
  iss.valid = may_idle ? r[0] : 1'b1;
  case (mode)
    MODE_ALU: begin
      r = rand_bits(3);
      iss.op = fu_pkg::alu_op_e'(4'(r % 64'd5));
    end
    MODE_SHIFT: begin
      r = rand_bits(2);
      iss.op = fu_pkg::alu_op_e'(4'(64'd5 + r % 64'd3));
    end
    default: begin
      r = rand_bits(3);
      iss.op = fu_pkg::alu_op_e'(4'(r));
    end
  endcase
  iss.a = rand_bits(64);
  iss.b = (mode == MODE_SHIFT) ? rand_bits(6) : rand_bits(64); // Shift amount 0 to 63
  if (fwd_on) begin
    iss.sel_a = pick_sel();
    iss.sel_b = pick_sel();
  end
  return iss;
endfunction

function automatic void model_reset();
  expect_t idle;
  idle = '0;
  exp_q.delete();
  exp_q.push_back(idle); // Cycles still covered by reset
  exp_q.push_back(idle);
  hist_now = '0;
  hist_prev = '0;
  now_ok = '0;
  prev_ok = '0;
endfunction

// A flush also kills the operations issued one cycle earlier
function automatic void model_flush();
  expect_t last;
  last = exp_q.pop_back();
  last.valid = '0;
  exp_q.push_back(last);
  now_ok = '0;
endfunction

function automatic void model_issue(input logic flushed);
  expect_t e;
  fu_pkg::data_t a;
  fu_pkg::data_t b;
  e = '0;
  for (int i = 0; i < fu_pkg::LANE_COUNT; i++) begin
    a = resolve(next_ops[i].sel_a, next_ops[i].a);
    b = resolve(next_ops[i].sel_b, next_ops[i].b);
    e.data[i] = alu_model(next_ops[i].op, a, b);
    e.valid[i] = next_ops[i].valid & ~flushed;
  end
  hist_prev = hist_now;
  prev_ok = now_ok;
  hist_now = e.data;
  now_ok = e.valid;
  exp_q.push_back(e);
endfunction

`endif

//--- dv/fu_cluster_tb.sv
`timescale 1ns/1ps

module fu_cluster_tb;

  localparam int CLK_PERIOD = 10;
  localparam int RESET_CYCLES = 16;
  localparam int IDLE_AFTER_RESET = 4;
  localparam int DRAIN_CYCLES = 2;
  localparam int ALU_CYCLES = 300;
  localparam int SHIFT_CYCLES = 300;
  localparam int FWD_CYCLES = 400;
  localparam int FLUSH_CYCLES = 400;
  localparam int SPARSE_CYCLES = 300;
  localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_AFTER_RESET + ALU_CYCLES + SHIFT_CYCLES
                              + FWD_CYCLES + FLUSH_CYCLES + SPARSE_CYCLES + 6 * DRAIN_CYCLES;
  localparam int WATCHDOG_CYCLES = TOTAL_CYCLES + 200;

  logic clk;
  logic reset;
  logic flush;
  fu_pkg::issue_t issue [fu_pkg::LANE_COUNT];
  fu_pkg::data_t result [fu_pkg::LANE_COUNT];
  logic [fu_pkg::LANE_COUNT-1:0] result_valid;

  int error_count;
  int check_count;
  int tests_run;
  int tests_failed;
  int test_err_start;
  int test_chk_start;

  `include "fu_cluster_model.svh"

  fu_cluster_top fu_cluster_top_inst (
    .clk(clk),
    .reset(reset),
    .flush(flush),
    .issue(issue),
    .result(result),
    .result_valid(result_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic compare_outputs(input expect_t e);
    for (int i = 0; i < fu_pkg::LANE_COUNT; i++) begin
      check_count++;
      if (result_valid[i] !== e.valid[i]) begin
        error_count++;
        $display("[ERROR] at %0t result_valid[%0d] got %b expected %b",
                 $time, i, result_valid[i], e.valid[i]);
      end
      if (e.valid[i] && result[i] !== e.data[i]) begin
        error_count++;
        $display("[ERROR] at %0t result[%0d] got %h expected %h",
                 $time, i, result[i], e.data[i]);
      end
    end
  endtask

  task automatic check_reset_state();
    for (int i = 0; i < fu_pkg::LANE_COUNT; i++) begin
      check_count++;
      if (result_valid[i] !== 1'b0) begin
        error_count++;
        $display("[ERROR] at %0t result_valid[%0d] got %b expected 0", $time, i, result_valid[i]);
      end
      if (result[i] !== '0) begin
        error_count++;
        $display("[ERROR] at %0t result[%0d] got %h expected 0", $time, i, result[i]);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Cycle driver
  ////////////////////////////////////////////////////////////

  // Drive one issue cycle, then check what was issued two cycles earlier
  task automatic run_cycle(input int mode, input bit fwd_on, input bit flush_on,
                           input logic [fu_pkg::LANE_COUNT-1:0] sparse);
    logic [63:0] r;
    logic do_flush;
    expect_t due;
    @(posedge clk);
    r = rand_bits(3);
    do_flush = flush_on && (r[2:0] == 3'd0);
    if (do_flush) begin
      model_flush();
    end
    for (int i = 0; i < fu_pkg::LANE_COUNT; i++) begin
      next_ops[i] = make_op(mode, fwd_on, sparse[i]);
    end
    model_issue(do_flush);
    flush <= do_flush;
    for (int i = 0; i < fu_pkg::LANE_COUNT; i++) begin
      issue[i] <= next_ops[i];
    end
    @(negedge clk);
    due = exp_q.pop_front();
    compare_outputs(due);
  endtask

  task automatic start_test();
    test_err_start = error_count;
    test_chk_start = check_count;
  endtask

  task automatic finish_test(input string name);
    int errs;
    repeat (DRAIN_CYCLES) run_cycle(MODE_IDLE, 1'b0, 1'b0, '0);
    errs = error_count - test_err_start;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("Test %s finished with %0d checks and %0d errors",
             name, check_count - test_chk_start, errs);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    reset = 1'b1;
    flush = 1'b0;
    for (int i = 0; i < fu_pkg::LANE_COUNT; i++) begin
      issue[i] = '0;
    end
    lfsr_state = LFSR_SEED;
    error_count = 0;
    check_count = 0;
    tests_run = 0;
    tests_failed = 0;

    start_test();
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(posedge clk);
      if (c == RESET_CYCLES - 1) begin
        reset <= 1'b0;
      end
      // Valid operations keep coming while reset is high and must never show up
      for (int i = 0; i < fu_pkg::LANE_COUNT; i++) begin
        if (c < RESET_CYCLES - 1) begin
          issue[i] <= make_op(MODE_ANY, 1'b0, 1'b0);
        end else begin
          issue[i] <= '0; // Sampled by the first edge out of reset
        end
      end
      @(negedge clk);
      check_reset_state();
    end
    model_reset();
    repeat (IDLE_AFTER_RESET) run_cycle(MODE_IDLE, 1'b0, 1'b0, '0);
    finish_test("reset");

    start_test();
    repeat (ALU_CYCLES) run_cycle(MODE_ALU, 1'b0, 1'b0, '0);
    finish_test("arith_logic");

    start_test();
    repeat (SHIFT_CYCLES) run_cycle(MODE_SHIFT, 1'b0, 1'b0, '0);
    finish_test("shifts");

    start_test();
    repeat (FWD_CYCLES) run_cycle(MODE_ANY, 1'b1, 1'b0, '0);
    finish_test("forwarding");

    start_test();
    repeat (FLUSH_CYCLES) run_cycle(MODE_ANY, 1'b1, 1'b1, '0);
    finish_test("flush");

    // Lanes 2 and 3 skip cycles while lanes 0 and 1 issue every cycle
    start_test();
    repeat (SPARSE_CYCLES) run_cycle(MODE_ANY, 1'b1, 1'b0, 4'b1100);
    finish_test("idle_slots");

    $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+dv
logic/fu_pkg.sv
logic/op_predecode.sv
logic/operand_forward.sv
logic/alu_lane.sv
logic/result_bus.sv
logic/fu_cluster_top.sv
dv/fu_cluster_tb.sv

//--- logic/alu_lane.sv
`timescale 1ns/1ps

module alu_lane (
  input fu_pkg::lane_ctrl_t ctrl,
  input fu_pkg::data_t bus_now [fu_pkg::LANE_COUNT],
  input fu_pkg::data_t bus_prev [fu_pkg::LANE_COUNT],
  output fu_pkg::data_t lane_result,
  output logic lane_valid
);

  fu_pkg::data_t opnd_a;
  fu_pkg::data_t opnd_b;
  fu_pkg::data_t sum;
  fu_pkg::data_t logic_out;
  fu_pkg::data_t shift_out;
  logic [fu_pkg::SHAMT_WIDTH-1:0] shamt;

  ////////////////////////////////////////////////////////////
  // Operand resolve
  ////////////////////////////////////////////////////////////

  operand_forward a_fwd (
    .sel(ctrl.sel_a),
    .issued(ctrl.a),
    .bus_now(bus_now),
    .bus_prev(bus_prev),
    .operand(opnd_a)
  );

  operand_forward b_fwd (
    .sel(ctrl.sel_b),
    .issued(ctrl.b),
    .bus_now(bus_now),
    .bus_prev(bus_prev),
    .operand(opnd_b)
  );

  ////////////////////////////////////////////////////////////
  // Execution units
  ////////////////////////////////////////////////////////////

  // Subtract is a plus inverted b plus one
  always_comb begin
    sum = opnd_a + (ctrl.is_sub ? ~opnd_b : opnd_b)
        + {{(fu_pkg::DATA_WIDTH-1){1'b0}}, ctrl.is_sub};
  end

  always_comb begin
    case (ctrl.logic_fn)
      fu_pkg::LOGIC_AND: logic_out = opnd_a & opnd_b;
      fu_pkg::LOGIC_OR: logic_out = opnd_a | opnd_b;
      default: logic_out = opnd_a ^ opnd_b;
    endcase
  end

  assign shamt = opnd_b[fu_pkg::SHAMT_WIDTH-1:0];

  // Barrel shifter built as a right shifter
  // A left shift reverses the word on the way in and again on the way out
  always_comb begin
    fu_pkg::data_t val;
    fu_pkg::data_t fill_mask;
    logic fill;
    fill = ctrl.shift_arith & opnd_a[fu_pkg::DATA_WIDTH-1];
    val = ctrl.shift_right ? opnd_a : {<<{opnd_a}};
    for (int s = 0; s < fu_pkg::SHAMT_WIDTH; s++) begin
      fill_mask = ~({fu_pkg::DATA_WIDTH{1'b1}} >> (1 << s));
      if (shamt[s]) begin
        val = (val >> (1 << s)) | (fill ? fill_mask : '0);
      end
    end
    shift_out = ctrl.shift_right ? val : {<<{val}};
  end

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (ctrl.is_shift) begin
      lane_result = shift_out;
    end else if (ctrl.logic_fn != fu_pkg::LOGIC_NONE) begin
      lane_result = logic_out;
    end else begin
      lane_result = sum; // Add and sub wrap at 64 bits
    end
  end

  assign lane_valid = ctrl.valid;

endmodule

//--- logic/fu_cluster_top.sv
`timescale 1ns/1ps

module fu_cluster_top (
  input logic clk,
  input logic reset,
  input logic flush,
  input fu_pkg::issue_t issue [fu_pkg::LANE_COUNT],
  output fu_pkg::data_t result [fu_pkg::LANE_COUNT],
  output logic [fu_pkg::LANE_COUNT-1:0] result_valid
);

  fu_pkg::lane_ctrl_t ctrl [fu_pkg::LANE_COUNT];
  fu_pkg::data_t lane_result [fu_pkg::LANE_COUNT];
  logic [fu_pkg::LANE_COUNT-1:0] lane_valid;
  fu_pkg::data_t bus_now [fu_pkg::LANE_COUNT];
  fu_pkg::data_t bus_prev [fu_pkg::LANE_COUNT];

  op_predecode predecode_inst (
    .clk(clk),
    .reset(reset),
    .flush(flush),
    .issue(issue),
    .ctrl(ctrl)
  );

  ////////////////////////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < fu_pkg::LANE_COUNT; i++) begin : g_lane
    alu_lane lane_inst (
      .ctrl(ctrl[i]),
      .bus_now(bus_now),
      .bus_prev(bus_prev),
      .lane_result(lane_result[i]),
      .lane_valid(lane_valid[i])
    );
  end

  result_bus result_bus_inst (
    .clk(clk),
    .reset(reset),
    .lane_result(lane_result),
    .lane_valid(lane_valid),
    .bus_now(bus_now),
    .bus_prev(bus_prev),
    .result(result),
    .result_valid(result_valid)
  );

endmodule

//--- logic/fu_pkg.sv
package fu_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  localparam int LANE_COUNT = 4;
  localparam int DATA_WIDTH = 64;

  // A select is a source kind followed by a lane index
  localparam int SEL_WIDTH = 4;
  localparam int SRC_WIDTH = 2;
  localparam int LANE_IDX_WIDTH = SEL_WIDTH - SRC_WIDTH;

  localparam int OP_WIDTH = 4;
  localparam int SHAMT_WIDTH = $clog2(DATA_WIDTH); // 6 bits for a 64-bit word

  // Logic unit function codes, zero means the lane is not doing a logic op
  localparam logic [1:0] LOGIC_NONE = 2'd0;
  localparam logic [1:0] LOGIC_AND = 2'd1;
  localparam logic [1:0] LOGIC_OR = 2'd2;
  localparam logic [1:0] LOGIC_XOR = 2'd3;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [DATA_WIDTH-1:0] data_t;

  typedef enum logic [OP_WIDTH-1:0] {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_and = 4'd2,
    op_or = 4'd3,
    op_xor = 4'd4,
    op_shl = 4'd5,
    op_shr = 4'd6,
    op_sar = 4'd7
  } alu_op_e;

  typedef enum logic [SRC_WIDTH-1:0] {
    src_issue = 2'd0, // Value carried with the operation
    src_now = 2'd1,   // Result bus of this cycle
    src_prev = 2'd2   // Result bus of the cycle before
  } fwd_src_e;

  typedef struct packed {
    fwd_src_e src;
    logic [LANE_IDX_WIDTH-1:0] lane;
  } fwd_sel_t;

  typedef struct packed {
    logic valid;
    alu_op_e op;
    data_t a;
    data_t b;
    fwd_sel_t sel_a;
    fwd_sel_t sel_b;
  } issue_t;

  // Decoded control, produced one cycle ahead of the lane
  typedef struct packed {
    logic valid;
    logic is_sub;
    logic [1:0] logic_fn;
    logic is_shift;
    logic shift_right;
    logic shift_arith;
    data_t a;
    data_t b;
    fwd_sel_t sel_a;
    fwd_sel_t sel_b;
  } lane_ctrl_t;

endpackage

//--- logic/op_predecode.sv
`timescale 1ns/1ps

module op_predecode (
  input logic clk,
  input logic reset,
  input logic flush,
  input fu_pkg::issue_t issue [fu_pkg::LANE_COUNT],
  output fu_pkg::lane_ctrl_t ctrl [fu_pkg::LANE_COUNT]
);

  fu_pkg::lane_ctrl_t ctrl_d [fu_pkg::LANE_COUNT];
  fu_pkg::lane_ctrl_t ctrl_q [fu_pkg::LANE_COUNT];

  ////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////

  function automatic fu_pkg::lane_ctrl_t decode_op(input fu_pkg::issue_t op_in);
    fu_pkg::lane_ctrl_t c;
    c = '0;
    c.valid = op_in.valid;
    c.a = op_in.a;
    c.b = op_in.b;
    c.sel_a = op_in.sel_a;
    c.sel_b = op_in.sel_b;
    case (op_in.op)
      fu_pkg::op_sub: c.is_sub = 1'b1;
      fu_pkg::op_and: c.logic_fn = fu_pkg::LOGIC_AND;
      fu_pkg::op_or: c.logic_fn = fu_pkg::LOGIC_OR;
      fu_pkg::op_xor: c.logic_fn = fu_pkg::LOGIC_XOR;
      fu_pkg::op_shl: c.is_shift = 1'b1;
      fu_pkg::op_shr: begin
        c.is_shift = 1'b1;
        c.shift_right = 1'b1;
      end
      fu_pkg::op_sar: begin
        c.is_shift = 1'b1;
        c.shift_right = 1'b1;
        c.shift_arith = 1'b1; // Fill with the sign of a
      end
      default: ; // Add, and any unused code behaves as add
    endcase
    return c;
  endfunction

  always_comb begin
    for (int i = 0; i < fu_pkg::LANE_COUNT; i++) begin
      ctrl_d[i] = decode_op(issue[i]);
    end
  end

  ////////////////////////////////////////////////////////////
  // Control register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    for (int i = 0; i < fu_pkg::LANE_COUNT; i++) begin
      ctrl_q[i] <= ctrl_d[i];
      if (reset || flush) begin
        ctrl_q[i].valid <= 1'b0; // Flush drops what is being issued now
      end
    end
  end

  // Flush also kills the operation already sitting in the register
  always_comb begin
    for (int i = 0; i < fu_pkg::LANE_COUNT; i++) begin
      ctrl[i] = ctrl_q[i];
      ctrl[i].valid = ctrl_q[i].valid & ~flush;
    end
  end

endmodule

//--- logic/operand_forward.sv
`timescale 1ns/1ps

module operand_forward (
  input fu_pkg::fwd_sel_t sel,
  input fu_pkg::data_t issued,
  input fu_pkg::data_t bus_now [fu_pkg::LANE_COUNT],
  input fu_pkg::data_t bus_prev [fu_pkg::LANE_COUNT],
  output fu_pkg::data_t operand
);

  // Two forwarding levels
  // bus_now holds results of operations issued two cycles before the current one,
  // bus_prev holds those issued three cycles before
  always_comb begin
    case (sel.src)
      fu_pkg::src_now: operand = bus_now[sel.lane];
      fu_pkg::src_prev: operand = bus_prev[sel.lane];
      default: operand = issued;
    endcase
  end

endmodule

//--- logic/result_bus.sv
`timescale 1ns/1ps

module result_bus (
  input logic clk,
  input logic reset,
  input fu_pkg::data_t lane_result [fu_pkg::LANE_COUNT],
  input logic [fu_pkg::LANE_COUNT-1:0] lane_valid,
  output fu_pkg::data_t bus_now [fu_pkg::LANE_COUNT],
  output fu_pkg::data_t bus_prev [fu_pkg::LANE_COUNT],
  output fu_pkg::data_t result [fu_pkg::LANE_COUNT],
  output logic [fu_pkg::LANE_COUNT-1:0] result_valid
);

  fu_pkg::data_t now_q [fu_pkg::LANE_COUNT];
  fu_pkg::data_t prev_q [fu_pkg::LANE_COUNT];
  logic [fu_pkg::LANE_COUNT-1:0] valid_q;

  ////////////////////////////////////////////////////////////
  // Bus registers
  ////////////////////////////////////////////////////////////

  // Data loads every cycle, valid alone says whether a slot means anything
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < fu_pkg::LANE_COUNT; i++) begin
        now_q[i] <= '0;
        prev_q[i] <= '0;
      end
      valid_q <= '0;
    end else begin
      for (int i = 0; i < fu_pkg::LANE_COUNT; i++) begin
        now_q[i] <= lane_result[i];
        prev_q[i] <= now_q[i]; // Second forwarding level
      end
      valid_q <= lane_valid;
    end
  end

  // The same registers feed the lanes and leave the cluster
  always_comb begin
    for (int i = 0; i < fu_pkg::LANE_COUNT; i++) begin
      bus_now[i] = now_q[i];
      bus_prev[i] = prev_q[i];
      result[i] = now_q[i];
    end
  end

  assign result_valid = valid_q;

endmodule
